// ==== build.f ====
+incdir+testbench
hdl/ex_pkg.sv
hdl/ex_if.sv
hdl/ex_alu.sv
hdl/ex_divider.sv
hdl/ex_lsu_addr.sv
hdl/ex_decode.sv
hdl/ex_execute.sv
hdl/ex_result.sv
hdl/ex_stage.sv
testbench/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - hdl/ex_pkg.sv
      - hdl/ex_if.sv
      - hdl/ex_alu.sv
      - hdl/ex_divider.sv
      - hdl/ex_lsu_addr.sv
      - hdl/ex_decode.sv
      - hdl/ex_execute.sv
      - hdl/ex_result.sv
      - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ex_stage_tb.sv

// ==== testbench/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

typedef struct packed {
    logic        wb_we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        ale;
    logic        ine;
    logic        mem_valid;
    logic        mem_we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
} exp_t;

// LA32 divide truncates toward zero
function automatic logic [31:0] div_model(logic [31:0] a, logic [31:0] b, logic sgn,
                                          logic rem);
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    ma = (sgn && a[31]) ? (~a + 32'd1) : a;
    mb = (sgn && b[31]) ? (~b + 32'd1) : b;
    q  = ma / mb;
    r  = ma % mb;
    if (rem) begin
        return (sgn && a[31]) ? (~r + 32'd1) : r;
    end
    return (sgn && (a[31] != b[31])) ? (~q + 32'd1) : q;
endfunction

function automatic exp_t ref_model(logic [31:0] inst, logic [31:0] rj, logic [31:0] rk);
    exp_t        e;
    logic [31:0] imm;
    logic [1:0]  off;
    int          size;
    logic        st;
    e      = '0;
    e.rd   = inst[4:0];
    imm    = {{20{inst[21]}}, inst[21:10]};
    e.addr = rj + imm;
    off    = e.addr[1:0];
    size   = 0;
    st     = 1'b0;
    e.wb_we = 1'b1;
    case (inst[31:15])
        OPC_ADD_W:  e.data = rj + rk;
        OPC_SUB_W:  e.data = rj - rk;
        OPC_SLT:    e.data = ($signed(rj) < $signed(rk)) ? 32'd1 : 32'd0;
        OPC_SLTU:   e.data = (rj < rk) ? 32'd1 : 32'd0;
        OPC_AND:    e.data = rj & rk;
        OPC_OR:     e.data = rj | rk;
        OPC_XOR:    e.data = rj ^ rk;
        OPC_SLL_W:  e.data = rj << rk[4:0];
        OPC_SRL_W:  e.data = rj >> rk[4:0];
        // logical shift with the vacated top bits filled from the sign
        OPC_SRA_W:  e.data = (rj >> rk[4:0])
                             | (rj[31] ? ~(32'hFFFF_FFFF >> rk[4:0]) : 32'd0);
        OPC_DIV_W:  e.data = div_model(rj, rk, 1'b1, 1'b0);
        OPC_MOD_W:  e.data = div_model(rj, rk, 1'b1, 1'b1);
        OPC_DIV_WU: e.data = div_model(rj, rk, 1'b0, 1'b0);
        OPC_MOD_WU: e.data = div_model(rj, rk, 1'b0, 1'b1);
        default: begin
            e.wb_we = 1'b0;
            case (inst[31:22])
                OPC_ADDI_W: begin
                    e.wb_we = 1'b1;
                    e.data  = rj + imm;
                end
                OPC_LD_B: size = 1;
                OPC_LD_H: size = 2;
                OPC_LD_W: size = 4;
                OPC_ST_B: begin
                    size = 1;
                    st   = 1'b1;
                end
                OPC_ST_H: begin
                    size = 2;
                    st   = 1'b1;
                end
                OPC_ST_W: begin
                    size = 4;
                    st   = 1'b1;
                end
                default: e.ine = 1'b1;
            endcase
        end
    endcase
    if (size != 0) begin
        e.ale       = (size == 2 && off[0]) || (size == 4 && off != 2'b00);
        e.mem_valid = !e.ale;
        e.mem_we    = st;
        e.wstrb     = 4'b1111;
        if (st && size == 1) begin
            e.wstrb             = 4'b0001 << off;
            e.wdata[8*off +: 8] = rk[7:0];
        end else if (st && size == 2) begin
            e.wstrb                   = 4'b0011 << (2 * off[1]);
            e.wdata[16*off[1] +: 16] = rk[15:0];
        end else if (st) begin
            e.wdata = rk;
        end
    end
    return e;
endfunction

`endif

// ==== testbench/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb
    import ex_pkg::*;
();

    `include "ex_ref_model.svh"

    localparam int N_INST = 283;
    localparam int LIMIT  = N_INST * 40 + 200;

    logic        clk;
    logic        rst_n_i;
    logic        in_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [31:0] rj_data_i;
    logic [31:0] rk_data_i;
    logic        stall_o;
    logic        wb_valid_o;
    logic        wb_we_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        ale_o;
    logic        ine_o;
    logic        mem_valid_o;
    logic        mem_we_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_wdata_o;
    logic [3:0]  mem_wstrb_o;

    exp_t exp_q[$];
    int   errors;
    int   checks;
    int   cycles;
    bit   div_pending;

    ex_stage ex_stage_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped after %0d cycles, DUT stopped responding", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_wb(logic we, logic [4:0] rd, logic [31:0] data, logic ale,
                            logic ine, exp_t e);
        checks++;
        if (we !== e.wb_we || ale !== e.ale || ine !== e.ine) begin
            errors++;
            $display("Mismatch at %0t: we/ale/ine %b%b%b expected %b%b%b", $time,
                     we, ale, ine, e.wb_we, e.ale, e.ine);
        end else if (e.wb_we && (rd !== e.rd || data !== e.data)) begin
            errors++;
            $display("Mismatch at %0t: rd %0d data %h expected rd %0d data %h", $time,
                     rd, data, e.rd, e.data);
        end
    endtask

    task automatic check_mem(logic valid, logic we, logic [31:0] addr, logic [31:0] wdata,
                             logic [3:0] wstrb, exp_t e);
        checks++;
        if (valid !== e.mem_valid) begin
            errors++;
            $display("Mismatch at %0t: mem_valid %b expected %b", $time, valid, e.mem_valid);
        end else if (valid && (we !== e.mem_we || addr !== e.addr || wdata !== e.wdata
                               || wstrb !== e.wstrb)) begin
            errors++;
            $display("Mismatch at %0t: mem we %b addr %h data %h strb %b expected %b %h %h %b",
                     $time, we, addr, wdata, wstrb, e.mem_we, e.addr, e.wdata, e.wstrb);
        end
    endtask

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Write-back at %0t with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                check_wb(wb_we_o, wb_rd_o, wb_data_o, ale_o, ine_o, e);
                check_mem(mem_valid_o, mem_we_o, mem_addr_o, mem_wdata_o, mem_wstrb_o, e);
            end
        end else if (rst_n_i && mem_valid_o) begin
            errors++;
            $display("Memory request at %0t without a write-back record", $time);
        end
    end

    function automatic bit is_div_word(logic [31:0] inst);
        logic [16:0] opc;
        opc = inst[31:15];
        return (opc == OPC_DIV_W) || (opc == OPC_MOD_W) || (opc == OPC_DIV_WU)
               || (opc == OPC_MOD_WU);
    endfunction

    function automatic logic [31:0] enc3r(logic [16:0] opc);
        return {opc, 5'($urandom), 5'($urandom), 5'($urandom)};
    endfunction

    function automatic logic [31:0] enc2ri(logic [9:0] opc, logic [11:0] si12);
        return {opc, si12, 5'($urandom), 5'($urandom)};
    endfunction

    // drives on the falling edge and holds until accepted
    task automatic issue(logic [31:0] inst, logic [31:0] rj, logic [31:0] rk);
        @(negedge clk);
        in_valid_i = 1'b1;
        inst_i     = inst;
        rj_data_i  = rj;
        rk_data_i  = rk;
        pc_i       = $urandom;
        exp_q.push_back(ref_model(inst, rj, rk));
        forever begin
            #1;
            if (div_pending && wb_valid_o) begin
                div_pending = 1'b0;
                if (!is_div_word(inst) && stall_o !== 1'b0) begin
                    errors++;
                    $display("Stall still high at %0t when the divide wrote back", $time);
                end
            end else if (div_pending && stall_o !== 1'b1) begin
                errors++;
                $display("Stall low at %0t while a divide is running", $time);
            end
            @(posedge clk);
            if (!div_pending) begin
                break;
            end
            @(negedge clk);
        end
        div_pending = is_div_word(inst);
    endtask

    task automatic idle_and_drain();
        @(negedge clk);
        in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        div_pending = 1'b0;
    endtask

    task automatic report_test(string name, int err_before);
        $display("%s: %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAILED",
                 errors - err_before);
    endtask

    initial begin
        logic [16:0] ops3[10];
        logic [16:0] divs[4];
        logic [9:0]  sts[3];
        logic [9:0]  lds[3];
        logic [31:0] base;
        logic [31:0] rk;
        logic [11:0] imm;
        int          e0;
        ops3 = '{OPC_ADD_W, OPC_SUB_W, OPC_SLT, OPC_SLTU, OPC_AND, OPC_OR, OPC_XOR,
                 OPC_SLL_W, OPC_SRL_W, OPC_SRA_W};
        divs = '{OPC_DIV_W, OPC_MOD_W, OPC_DIV_WU, OPC_MOD_WU};
        sts  = '{OPC_ST_B, OPC_ST_H, OPC_ST_W};
        lds  = '{OPC_LD_B, OPC_LD_H, OPC_LD_W};
        void'($urandom(81393));
        clk = 1'b0;
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        rj_data_i = '0;
        rk_data_i = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        div_pending = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        e0 = errors;
        @(negedge clk);
        if (stall_o !== 1'b0 || wb_valid_o !== 1'b0 || mem_valid_o !== 1'b0
            || ale_o !== 1'b0 || ine_o !== 1'b0) begin
            errors++;
            $display("Outputs not idle after reset");
        end
        report_test("reset state", e0);

        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            if (i % 5 == 4) begin
                issue(enc2ri(OPC_ADDI_W, 12'($urandom)), $urandom, $urandom);
            end else begin
                issue(enc3r(ops3[$urandom_range(0, 9)]), $urandom, $urandom);
            end
        end
        idle_and_drain();
        report_test("alu back to back", e0);

        e0 = errors;
        issue({OPC_DIV_W, 15'h1234}, 32'h8000_0000, 32'hFFFF_FFFF);
        issue({OPC_MOD_W, 15'h1234}, 32'h8000_0000, 32'hFFFF_FFFF);
        for (int i = 0; i < 40; i++) begin
            rk = (i % 2 == 0) ? $urandom : 32'($signed($urandom_range(0, 40)) - 20);
            if (rk == 0) begin
                rk = 32'd7;
            end
            issue(enc3r(divs[i % 4]), $urandom, rk);
            // an alu op right behind is held during the stall
            if (i % 3 == 0) begin
                issue(enc3r(OPC_ADD_W), $urandom, $urandom);
            end
        end
        idle_and_drain();
        report_test("divide and modulo", e0);

        e0 = errors;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                imm  = 12'($urandom);
                base = $urandom;
                base = base - ((base + {{20{imm[11]}}, imm}) & 32'd3) + off;
                issue(enc2ri(sts[s], imm), base, $urandom);
            end
        end
        idle_and_drain();
        report_test("stores", e0);

        e0 = errors;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                imm  = 12'($urandom);
                base = $urandom;
                base = base - ((base + {{20{imm[11]}}, imm}) & 32'd3) + off;
                issue(enc2ri(lds[s], imm), base, $urandom);
            end
        end
        idle_and_drain();
        report_test("loads", e0);

        e0 = errors;
        issue(32'hFFFF_FFFF, $urandom, $urandom);
        issue(32'h0000_0000, $urandom, $urandom);
        issue(32'h3800_0000, $urandom, $urandom);
        idle_and_drain();
        report_test("invalid words", e0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage #(
    parameter int DIV_BITS = 1
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    input  logic [31:0] inst_i,
    // no pc-relative ops in this subset
    input  logic [31:0] pc_i,
    input  logic [31:0] rj_data_i,
    input  logic [31:0] rk_data_i,
    output logic        stall_o,
    output logic        wb_valid_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    output logic        ale_o,
    output logic        ine_o,
    output logic        mem_valid_o,
    output logic        mem_we_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    output logic [3:0]  mem_wstrb_o
);

    ex_dec_if dec_if ();
    ex_res_if res_if ();

    ex_decode decode_i (
        .in_valid_i (in_valid_i),
        .inst_i     (inst_i),
        .rj_data_i  (rj_data_i),
        .rk_data_i  (rk_data_i),
        .dec_o      (dec_if.decode)
    );

    ex_execute #(
        .DIV_BITS (DIV_BITS)
    ) execute_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dec_i   (dec_if.execute),
        .res_o   (res_if.execute),
        .stall_o (stall_o)
    );

    ex_result result_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .res_i       (res_if.result),
        .wb_valid_o  (wb_valid_o),
        .wb_we_o     (wb_we_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .ale_o       (ale_o),
        .ine_o       (ine_o),
        .mem_valid_o (mem_valid_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o)
    );

endmodule

// ==== hdl/ex_result.sv ====
`timescale 1ns/1ps

module ex_result
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    ex_res_if.result    res_i,
    output logic        wb_valid_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    output logic        ale_o,
    output logic        ine_o,
    output logic        mem_valid_o,
    output logic        mem_we_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    output logic [3:0]  mem_wstrb_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o  <= 1'b0;
            wb_we_o     <= 1'b0;
            ale_o       <= 1'b0;
            ine_o       <= 1'b0;
            mem_valid_o <= 1'b0;
        end else if (res_i.div_done) begin
            // input is stalled, no issue in this cycle
            wb_valid_o  <= 1'b1;
            wb_we_o     <= 1'b1;
            ale_o       <= 1'b0;
            ine_o       <= 1'b0;
            mem_valid_o <= 1'b0;
        end else begin
            wb_valid_o  <= res_i.issue_valid;
            wb_we_o     <= res_i.issue_valid && res_i.issue_we;
            ale_o       <= res_i.issue_valid && res_i.ale;
            ine_o       <= res_i.issue_valid && res_i.issue_ine;
            mem_valid_o <= res_i.issue_valid && res_i.mem_req;
        end
    end

    always_ff @(posedge clk) begin
        if (res_i.div_done) begin
            wb_rd_o   <= res_i.div_rd;
            wb_data_o <= res_i.div_res;
        end else begin
            wb_rd_o   <= res_i.issue_rd;
            wb_data_o <= (res_i.issue_sel == SEL_ALU) ? res_i.alu_res : 32'd0;
        end
        mem_we_o    <= res_i.mem_we;
        mem_addr_o  <= res_i.mem_addr;
        mem_wdata_o <= res_i.mem_wdata;
        mem_wstrb_o <= res_i.mem_wstrb;
    end

endmodule

// ==== hdl/ex_execute.sv ====
`timescale 1ns/1ps

module ex_execute
    import ex_pkg::*;
#(
    parameter int DIV_BITS = 1
) (
    input  logic      clk,
    input  logic      rst_n_i,
    ex_dec_if.execute dec_i,
    ex_res_if.execute res_o,
    output logic      stall_o
);

    logic        accept;
    logic        div_start;
    logic        div_busy;
    logic [31:0] alu_b;

    // only a running divide blocks acceptance
    assign accept    = dec_i.valid && !div_busy;
    assign div_start = accept && (dec_i.sel == SEL_DIV);
    assign stall_o   = div_start || div_busy;

    assign alu_b = (dec_i.op == ADDI_W) ? dec_i.imm : dec_i.rk_data;

    ex_alu alu_i (
        .op_i  (dec_i.op),
        .a_i   (dec_i.rj_data),
        .b_i   (alu_b),
        .res_o (res_o.alu_res)
    );

    ex_divider #(
        .DIV_BITS (DIV_BITS)
    ) divider_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   ((dec_i.op == DIV_W) || (dec_i.op == MOD_W)),
        .rem_i      ((dec_i.op == MOD_W) || (dec_i.op == MOD_WU)),
        .rd_i       (dec_i.rd),
        .dividend_i (dec_i.rj_data),
        .divisor_i  (dec_i.rk_data),
        .busy_o     (div_busy),
        .done_o     (res_o.div_done),
        .rd_o       (res_o.div_rd),
        .res_o      (res_o.div_res)
    );

    ex_lsu_addr lsu_addr_i (
        .op_i         (dec_i.op),
        .base_i       (dec_i.rj_data),
        .imm_i        (dec_i.imm),
        .store_data_i (dec_i.rk_data),
        .req_o        (res_o.mem_req),
        .we_o         (res_o.mem_we),
        .addr_o       (res_o.mem_addr),
        .wdata_o      (res_o.mem_wdata),
        .wstrb_o      (res_o.mem_wstrb),
        .ale_o        (res_o.ale)
    );

    assign res_o.issue_valid = accept && (dec_i.sel != SEL_DIV);
    assign res_o.issue_sel   = dec_i.sel;
    assign res_o.issue_rd    = dec_i.rd;
    assign res_o.issue_we    = dec_i.we;
    assign res_o.issue_ine   = dec_i.ine;

endmodule

// ==== hdl/ex_decode.sv ====
`timescale 1ns/1ps

module ex_decode
    import ex_pkg::*;
(
    input  logic        in_valid_i,
    input  logic [31:0] inst_i,
    input  logic [31:0] rj_data_i,
    input  logic [31:0] rk_data_i,
    ex_dec_if.decode    dec_o
);

    logic [11:0] si12;
    ex_op_e      op;
    ex_sel_e     sel;
    logic        ine;

    assign si12 = inst_i[SI12_LSB +: 12];

    always_comb begin
        op  = NOP;
        ine = 1'b0;
        case (inst_i[31:15])
            OPC_ADD_W:  op = ADD_W;
            OPC_SUB_W:  op = SUB_W;
            OPC_SLT:    op = SLT;
            OPC_SLTU:   op = SLTU;
            OPC_AND:    op = AND;
            OPC_OR:     op = OR;
            OPC_XOR:    op = XOR;
            OPC_SLL_W:  op = SLL_W;
            OPC_SRL_W:  op = SRL_W;
            OPC_SRA_W:  op = SRA_W;
            OPC_DIV_W:  op = DIV_W;
            OPC_MOD_W:  op = MOD_W;
            OPC_DIV_WU: op = DIV_WU;
            OPC_MOD_WU: op = MOD_WU;
            default: begin
                // not 3R, try the 2RI12 codes
                case (inst_i[31:22])
                    OPC_ADDI_W: op = ADDI_W;
                    OPC_LD_B:   op = LD_B;
                    OPC_LD_H:   op = LD_H;
                    OPC_LD_W:   op = LD_W;
                    OPC_ST_B:   op = ST_B;
                    OPC_ST_H:   op = ST_H;
                    OPC_ST_W:   op = ST_W;
                    default:    ine = 1'b1;
                endcase
            end
        endcase
    end

    always_comb begin
        case (op)
            DIV_W, MOD_W, DIV_WU, MOD_WU: sel = SEL_DIV;
            LD_B, LD_H, LD_W, ST_B, ST_H, ST_W: sel = SEL_MEM;
            NOP:     sel = SEL_NONE;
            default: sel = SEL_ALU;
        endcase
    end

    assign dec_o.valid   = in_valid_i;
    assign dec_o.op      = op;
    assign dec_o.sel     = sel;
    assign dec_o.rd      = inst_i[RD_LSB +: 5];
    // loads write back later, outside this stage
    assign dec_o.we      = (sel == SEL_ALU) || (sel == SEL_DIV);
    assign dec_o.rj_data = rj_data_i;
    assign dec_o.rk_data = rk_data_i;
    assign dec_o.imm     = {{20{si12[11]}}, si12};
    assign dec_o.ine     = ine;

endmodule

// ==== hdl/ex_lsu_addr.sv ====
`timescale 1ns/1ps

module ex_lsu_addr
    import ex_pkg::*;
(
    input  ex_op_e      op_i,
    input  logic [31:0] base_i,
    input  logic [31:0] imm_i,
    input  logic [31:0] store_data_i,
    output logic        req_o,
    output logic        we_o,
    output logic [31:0] addr_o,
    output logic [31:0] wdata_o,
    output logic [3:0]  wstrb_o,
    output logic        ale_o
);

    logic [31:0] addr;
    logic        is_load;
    logic        is_store;
    logic        misaligned;

    assign addr = base_i + imm_i;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        wdata_o  = 32'd0;
        wstrb_o  = 4'b0000;
        case (op_i)
            LD_B, LD_H, LD_W: begin
                is_load = 1'b1;
                wstrb_o = 4'b1111;
            end
            ST_B: begin
                is_store = 1'b1;
                wdata_o  = {24'd0, store_data_i[7:0]} << {addr[1:0], 3'b000};
                wstrb_o  = 4'b0001 << addr[1:0];
            end
            ST_H: begin
                is_store = 1'b1;
                wdata_o  = {16'd0, store_data_i[15:0]} << {addr[1], 4'b0000};
                wstrb_o  = 4'b0011 << {addr[1], 1'b0};
            end
            ST_W: begin
                is_store = 1'b1;
                wdata_o  = store_data_i;
                wstrb_o  = 4'b1111;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    // halfword on even, word on 4-byte boundary
    always_comb begin
        case (op_i)
            LD_H, ST_H: misaligned = addr[0];
            LD_W, ST_W: misaligned = |addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    assign req_o  = (is_load || is_store) && !misaligned;
    assign we_o   = is_store;
    assign addr_o = addr;
    assign ale_o  = misaligned;

endmodule

// ==== hdl/ex_divider.sv ====
`timescale 1ns/1ps

module ex_divider #(
    parameter int DIV_BITS = 1
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic        rem_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [4:0]  rd_o,
    output logic [31:0] res_o
);

    localparam int STEPS = 32 / DIV_BITS;

    typedef enum logic [1:0] {IDLE, LOAD, ITER, FIX} div_state_e;

    div_state_e  state;
    logic [4:0]  cnt;
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic        sgn_q;
    logic        want_rem_q;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [31:0] rem_r;
    logic [31:0] quo_r;
    logic [31:0] rem_nx;
    logic [31:0] quo_nx;
    logic [32:0] shifted;

    assign a_mag = (sgn_q && a_q[31]) ? -a_q : a_q;
    assign b_mag = (sgn_q && b_q[31]) ? -b_q : b_q;

    // DIV_BITS restoring steps; LOAD already does the first group
    always_comb begin
        rem_nx  = (state == LOAD) ? 32'd0 : rem_r;
        quo_nx  = (state == LOAD) ? a_mag : quo_r;
        shifted = '0;
        for (int i = 0; i < DIV_BITS; i++) begin
            shifted = {rem_nx, quo_nx[31]};
            quo_nx  = {quo_nx[30:0], 1'b0};
            if (shifted >= {1'b0, b_mag}) begin
                shifted   = shifted - {1'b0, b_mag};
                quo_nx[0] = 1'b1;
            end
            rem_nx = shifted[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    state <= ITER;
                    cnt   <= '0;
                end
                ITER: begin
                    if (cnt == 5'(STEPS - 2)) begin
                        state <= FIX;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            a_q        <= dividend_i;
            b_q        <= divisor_i;
            sgn_q      <= signed_i;
            want_rem_q <= rem_i;
            rd_o       <= rd_i;
        end
        if (state == LOAD || state == ITER) begin
            rem_r <= rem_nx;
            quo_r <= quo_nx;
        end
    end

    // quotient negative on differing signs, remainder follows dividend
    always_comb begin
        if (want_rem_q) begin
            res_o = (sgn_q && a_q[31]) ? -rem_r : rem_r;
        end else begin
            res_o = (sgn_q && (a_q[31] ^ b_q[31])) ? -quo_r : quo_r;
        end
    end

    assign busy_o = (state != IDLE);
    assign done_o = (state == FIX);

endmodule

// ==== hdl/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
(
    input  ex_op_e      op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] res_o
);

    logic [4:0] sa;

    // shift amount from b[4:0] only
    assign sa = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD_W, ADDI_W: begin
                res_o = a_i + b_i;
            end
            SUB_W: begin
                res_o = a_i - b_i;
            end
            SLT: begin
                res_o = {31'd0, $signed(a_i) < $signed(b_i)};
            end
            SLTU: begin
                res_o = {31'd0, a_i < b_i};
            end
            AND: begin
                res_o = a_i & b_i;
            end
            OR: begin
                res_o = a_i | b_i;
            end
            XOR: begin
                res_o = a_i ^ b_i;
            end
            SLL_W: begin
                res_o = a_i << sa;
            end
            SRL_W: begin
                res_o = a_i >> sa;
            end
            SRA_W: begin
                res_o = $unsigned($signed(a_i) >>> sa);
            end
            default: begin
                res_o = 32'd0;
            end
        endcase
    end

endmodule

// ==== hdl/ex_if.sv ====
`timescale 1ns/1ps

// decode to execute
interface ex_dec_if
    import ex_pkg::*;
();
    logic        valid;
    ex_op_e      op;
    ex_sel_e     sel;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] rj_data;
    logic [31:0] rk_data;
    logic [31:0] imm;
    logic        ine;

    modport decode (output valid, op, sel, rd, we, rj_data, rk_data, imm, ine);
    modport execute (input valid, op, sel, rd, we, rj_data, rk_data, imm, ine);
endinterface

// execute to result
interface ex_res_if
    import ex_pkg::*;
();
    logic        issue_valid;
    ex_sel_e     issue_sel;
    logic [4:0]  issue_rd;
    logic        issue_we;
    logic        issue_ine;
    logic [31:0] alu_res;
    logic        div_done;
    logic [4:0]  div_rd;
    logic [31:0] div_res;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        ale;

    modport execute (output issue_valid, issue_sel, issue_rd, issue_we, issue_ine, alu_res,
                     div_done, div_rd, div_res, mem_req, mem_we, mem_addr, mem_wdata,
                     mem_wstrb, ale);
    modport result (input issue_valid, issue_sel, issue_rd, issue_we, issue_ine, alu_res,
                    div_done, div_rd, div_res, mem_req, mem_we, mem_addr, mem_wdata,
                    mem_wstrb, ale);
endinterface

// ==== hdl/ex_pkg.sv ====
package ex_pkg;

    // operations executed by this stage
    typedef enum logic [4:0] {
        ADD_W,
        SUB_W,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        SLL_W,
        SRL_W,
        SRA_W,
        ADDI_W,
        DIV_W,
        MOD_W,
        DIV_WU,
        MOD_WU,
        LD_B,
        LD_H,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        NOP
    } ex_op_e;

    // unit that produces the result
    typedef enum logic [1:0] {
        SEL_ALU,
        SEL_DIV,
        SEL_MEM,
        SEL_NONE
    } ex_sel_e;

    // 3R major codes, inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002A;
    localparam logic [16:0] OPC_XOR    = 17'h0002B;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002E;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002F;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;
    localparam logic [16:0] OPC_DIV_W  = 17'h00040;
    localparam logic [16:0] OPC_MOD_W  = 17'h00041;
    localparam logic [16:0] OPC_DIV_WU = 17'h00042;
    localparam logic [16:0] OPC_MOD_WU = 17'h00043;

    // 2RI12 major codes, inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC_LD_B   = 10'h0A0;
    localparam logic [9:0] OPC_LD_H   = 10'h0A1;
    localparam logic [9:0] OPC_LD_W   = 10'h0A2;
    localparam logic [9:0] OPC_ST_B   = 10'h0A4;
    localparam logic [9:0] OPC_ST_H   = 10'h0A5;
    localparam logic [9:0] OPC_ST_W   = 10'h0A6;

    // field positions, rd/rj/rk are 5 bits and si12 is 12
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int SI12_LSB = 10;

endpackage
